// ==== rtl/dp_pkg.sv ====
// Fixed two-wide dispatch. Queue sizes must stay below 16 so the free counts fit CNT_W bits.
`default_nettype none

package dp_pkg;

    // datapath widths.
    localparam int XLEN  = 32;
    localparam int IDX_W = 5;
    localparam int CNT_W = 4;

    // instructions accepted per cycle.
    localparam int DP_WIDTH = 2;

    // entry counts of the downstream queues.
    localparam int ROB_SIZE = 8;
    localparam int RS_SIZE  = 4;
    localparam int LSQ_SIZE = 4;

    // index used when a source or destination is not present.
    localparam logic [IDX_W-1:0] ZERO_REG = 5'd0;

    // funct3 codes of the integer ALU group.
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    // RV32I major opcodes handled by the decoder.
    typedef enum logic [6:0] {
        OPC_R      = 7'b0110011,
        OPC_IMM    = 7'b0010011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111,
        OPC_LUI    = 7'b0110111
    } opcode_e;

    // ALU operation, zero value is the cleared encoding.
    typedef enum logic [3:0] {
        ALU_ADD = 4'd0,
        ALU_SUB = 4'd1,
        ALU_AND = 4'd2,
        ALU_OR  = 4'd3,
        ALU_XOR = 4'd4,
        ALU_SLT = 4'd5,
        ALU_SLL = 4'd6,
        ALU_SRL = 4'd7
    } alu_func_e;

    // functional unit that will execute the instruction.
    typedef enum logic [1:0] {
        FU_ALU = 2'd0,
        FU_MEM = 2'd1,
        FU_BR  = 2'd2
    } fu_sel_e;

endpackage

`default_nettype wire

// ==== rtl/decoder.sv ====
// Handles R, OP-IMM, LOAD, STORE, BRANCH, JAL and LUI only. SLTU folds into SLT and SRA into SRL.
`default_nettype none

module decoder (
    input  logic [dp_pkg::XLEN-1:0]  inst,
    output dp_pkg::alu_func_e        alu_func,
    output dp_pkg::fu_sel_e          fu_sel,
    output logic [dp_pkg::IDX_W-1:0] rs1_idx,
    output logic [dp_pkg::IDX_W-1:0] rs2_idx,
    output logic [dp_pkg::IDX_W-1:0] dest_idx,
    output logic                     has_dest,
    output logic                     rd_mem,
    output logic                     wr_mem,
    output logic                     cond_branch,
    output logic                     uncond_branch,
    output logic                     illegal
);

    dp_pkg::opcode_e opcode;
    logic            use_rs1;
    logic            use_rs2;

    // map funct3 onto the reduced ALU set.
    function automatic dp_pkg::alu_func_e alu_from_funct3(
        input logic [2:0] f3,
        input logic       sub_sel
    );
        dp_pkg::alu_func_e f;
        case (f3)
            dp_pkg::F3_ADD:  f = sub_sel ? dp_pkg::ALU_SUB : dp_pkg::ALU_ADD;
            dp_pkg::F3_SLL:  f = dp_pkg::ALU_SLL;
            dp_pkg::F3_SLT:  f = dp_pkg::ALU_SLT;
            dp_pkg::F3_SLTU: f = dp_pkg::ALU_SLT;
            dp_pkg::F3_XOR:  f = dp_pkg::ALU_XOR;
            dp_pkg::F3_SR:   f = dp_pkg::ALU_SRL;
            dp_pkg::F3_OR:   f = dp_pkg::ALU_OR;
            dp_pkg::F3_AND:  f = dp_pkg::ALU_AND;
            default:         f = dp_pkg::ALU_ADD;
        endcase
        return f;
    endfunction

    assign opcode = dp_pkg::opcode_e'(inst[6:0]);

    always_comb begin
        alu_func      = dp_pkg::ALU_ADD;
        fu_sel        = dp_pkg::FU_ALU;
        use_rs1       = 1'b0;
        use_rs2       = 1'b0;
        has_dest      = 1'b0;
        rd_mem        = 1'b0;
        wr_mem        = 1'b0;
        cond_branch   = 1'b0;
        uncond_branch = 1'b0;
        illegal       = 1'b0;
        case (opcode)
            dp_pkg::OPC_R: begin
                // funct7 bit 5 only matters for the add/sub pair.
                alu_func = alu_from_funct3(inst[14:12], inst[30]);
                use_rs1  = 1'b1;
                use_rs2  = 1'b1;
                has_dest = 1'b1;
            end
            dp_pkg::OPC_IMM: begin
                alu_func = alu_from_funct3(inst[14:12], 1'b0);
                use_rs1  = 1'b1;
                has_dest = 1'b1;
            end
            dp_pkg::OPC_LOAD: begin
                fu_sel   = dp_pkg::FU_MEM;
                use_rs1  = 1'b1;
                has_dest = 1'b1;
                rd_mem   = 1'b1;
            end
            dp_pkg::OPC_STORE: begin
                fu_sel  = dp_pkg::FU_MEM;
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
                wr_mem  = 1'b1;
            end
            dp_pkg::OPC_BRANCH: begin
                // compare by subtraction.
                alu_func    = dp_pkg::ALU_SUB;
                fu_sel      = dp_pkg::FU_BR;
                use_rs1     = 1'b1;
                use_rs2     = 1'b1;
                cond_branch = 1'b1;
            end
            dp_pkg::OPC_JAL: begin
                fu_sel        = dp_pkg::FU_BR;
                has_dest      = 1'b1;
                uncond_branch = 1'b1;
            end
            dp_pkg::OPC_LUI: begin
                has_dest = 1'b1;
            end
            default: begin
                illegal = 1'b1;
            end
        endcase
    end

    // unused fields fall back to x0.
    assign rs1_idx  = use_rs1  ? inst[19:15] : dp_pkg::ZERO_REG;
    assign rs2_idx  = use_rs2  ? inst[24:20] : dp_pkg::ZERO_REG;
    assign dest_idx = has_dest ? inst[11:7]  : dp_pkg::ZERO_REG;

endmodule

`default_nettype wire

// ==== rtl/regfile.sv ====
// No reset and no same-cycle bypass. Contents are undefined until every register has been written.
`default_nettype none

module regfile (
    input  logic                                    clock,
    input  logic [1:0][dp_pkg::IDX_W-1:0]           read_idx_1,
    input  logic [1:0][dp_pkg::IDX_W-1:0]           read_idx_2,
    input  logic [1:0]                              write_en,
    input  logic [1:0][dp_pkg::IDX_W-1:0]           write_idx,
    input  logic [1:0][dp_pkg::XLEN-1:0]            write_data,
    output logic [1:0][dp_pkg::XLEN-1:0]            read_out_1,
    output logic [1:0][dp_pkg::XLEN-1:0]            read_out_2
);

    // x0 has no storage.
    logic [dp_pkg::XLEN-1:0] regs [1:31];

    // port 1 is applied last, so it wins on the same index.
    always_ff @(posedge clock) begin
        for (int p = 0; p < dp_pkg::DP_WIDTH; p++) begin
            if (write_en[p] && (write_idx[p] != dp_pkg::ZERO_REG)) begin
                regs[write_idx[p]] <= write_data[p];
            end
        end
    end

    // combinational reads, x0 forced to zero.
    always_comb begin
        for (int p = 0; p < dp_pkg::DP_WIDTH; p++) begin
            if (read_idx_1[p] == dp_pkg::ZERO_REG) begin
                read_out_1[p] = '0;
            end else begin
                read_out_1[p] = regs[read_idx_1[p]];
            end
            if (read_idx_2[p] == dp_pkg::ZERO_REG) begin
                read_out_2[p] = '0;
            end else begin
                read_out_2[p] = regs[read_idx_2[p]];
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/slot_tracker.sv ====
// Models only free-entry counts. Each dispatched instruction takes one ROB, RS and LSQ entry.
`default_nettype none

module slot_tracker (
    input  logic       clock,
    input  logic       reset,
    input  logic [1:0] dp_count,
    input  logic [1:0] rob_release,
    input  logic [1:0] rs_release,
    input  logic [1:0] lsq_release,
    output logic [1:0] rob_spaces,
    output logic [1:0] rs_spaces,
    output logic [1:0] lsq_spaces
);

    logic [dp_pkg::CNT_W-1:0] rob_free;
    logic [dp_pkg::CNT_W-1:0] rs_free;
    logic [dp_pkg::CNT_W-1:0] lsq_free;

    // net update, clamped to 0..size.
    function automatic logic [dp_pkg::CNT_W-1:0] next_count(
        input logic [dp_pkg::CNT_W-1:0] count,
        input logic [1:0]               rel,
        input logic [1:0]               taken,
        input int                       size
    );
        int total;
        total = int'(count) + int'(rel) - int'(taken);
        if (total < 0) begin
            total = 0;
        end else if (total > size) begin
            total = size;
        end
        return total[dp_pkg::CNT_W-1:0];
    endfunction

    // a stage never takes more than two per cycle.
    function automatic logic [1:0] cap_two(input logic [dp_pkg::CNT_W-1:0] count);
        return (count >= 2) ? 2'd2 : count[1:0];
    endfunction

    always_ff @(posedge clock) begin
        if (reset) begin
            rob_free <= dp_pkg::CNT_W'(dp_pkg::ROB_SIZE);
            rs_free  <= dp_pkg::CNT_W'(dp_pkg::RS_SIZE);
            lsq_free <= dp_pkg::CNT_W'(dp_pkg::LSQ_SIZE);
        end else begin
            rob_free <= next_count(rob_free, rob_release, dp_count, dp_pkg::ROB_SIZE);
            rs_free  <= next_count(rs_free, rs_release, dp_count, dp_pkg::RS_SIZE);
            lsq_free <= next_count(lsq_free, lsq_release, dp_count, dp_pkg::LSQ_SIZE);
        end
    end

    assign rob_spaces = cap_two(rob_free);
    assign rs_spaces  = cap_two(rs_free);
    assign lsq_spaces = cap_two(lsq_free);

endmodule

`default_nettype wire

// ==== rtl/stage_dp.sv ====
// Purely combinational dispatch. Fetch must keep its slots in order and resend what is not taken.
`default_nettype none

module stage_dp (
    input  logic                                 clock,
    input  logic [1:0]                           if_valid,
    input  logic [1:0][dp_pkg::XLEN-1:0]         if_inst,
    input  logic [1:0][dp_pkg::XLEN-1:0]         if_pc,
    input  logic [1:0]                           rt_valid,
    input  logic [1:0][dp_pkg::IDX_W-1:0]        rt_idx,
    input  logic [1:0][dp_pkg::XLEN-1:0]         rt_value,
    input  logic [1:0]                           rob_spaces,
    input  logic [1:0]                           rs_spaces,
    input  logic [1:0]                           lsq_spaces,
    output logic [1:0]                           dp_count,
    output logic [1:0]                           dp_valid,
    output logic [1:0][dp_pkg::XLEN-1:0]         dp_pc,
    output logic [1:0][dp_pkg::IDX_W-1:0]        dp_rs1_idx,
    output logic [1:0][dp_pkg::IDX_W-1:0]        dp_rs2_idx,
    output logic [1:0][dp_pkg::XLEN-1:0]         dp_rs1_value,
    output logic [1:0][dp_pkg::XLEN-1:0]         dp_rs2_value,
    output logic [1:0][dp_pkg::IDX_W-1:0]        dp_dest_idx,
    output logic [1:0]                           dp_has_dest,
    output dp_pkg::alu_func_e [1:0]              dp_alu_func,
    output dp_pkg::fu_sel_e [1:0]                dp_fu_sel,
    output logic [1:0]                           dp_rd_mem,
    output logic [1:0]                           dp_wr_mem,
    output logic [1:0]                           dp_cond_branch,
    output logic [1:0]                           dp_uncond_branch,
    output logic [1:0]                           dp_illegal
);

    logic [1:0] valid_cnt;
    logic [1:0] space;

    function automatic logic [1:0] min2(input logic [1:0] a, input logic [1:0] b);
        return (a <= b) ? a : b;
    endfunction

    // slot 1 only counts behind a valid slot 0.
    assign valid_cnt = if_valid[0] ? (if_valid[1] ? 2'd2 : 2'd1) : 2'd0;

    always_comb begin
        space    = min2(min2(rob_spaces, rs_spaces), lsq_spaces);
        dp_count = min2(space, valid_cnt);
        for (int s = 0; s < dp_pkg::DP_WIDTH; s++) begin
            dp_valid[s] = (2'(s) < dp_count);
        end
    end

    genvar i;
    generate
        for (i = 0; i < dp_pkg::DP_WIDTH; i++) begin : g_slot
            decoder decoder_i (
                .inst          (if_inst[i]),
                .alu_func      (dp_alu_func[i]),
                .fu_sel        (dp_fu_sel[i]),
                .rs1_idx       (dp_rs1_idx[i]),
                .rs2_idx       (dp_rs2_idx[i]),
                .dest_idx      (dp_dest_idx[i]),
                .has_dest      (dp_has_dest[i]),
                .rd_mem        (dp_rd_mem[i]),
                .wr_mem        (dp_wr_mem[i]),
                .cond_branch   (dp_cond_branch[i]),
                .uncond_branch (dp_uncond_branch[i]),
                .illegal       (dp_illegal[i])
            );
            assign dp_pc[i] = if_pc[i];
        end
    endgenerate

    // decoded indices drive the reads, so absent operands come back as x0.
    regfile regfile_i (
        .clock      (clock),
        .read_idx_1 (dp_rs1_idx),
        .read_idx_2 (dp_rs2_idx),
        .write_en   (rt_valid),
        .write_idx  (rt_idx),
        .write_data (rt_value),
        .read_out_1 (dp_rs1_value),
        .read_out_2 (dp_rs2_value)
    );

endmodule

`default_nettype wire

// ==== rtl/dispatch_top.sv ====
// Register file has no reset. Releases come from the back end and are clamped at each queue size.
`default_nettype none

module dispatch_top (
    input  logic                                 clock,
    input  logic                                 reset,
    input  logic [1:0]                           if_valid,
    input  logic [1:0][dp_pkg::XLEN-1:0]         if_inst,
    input  logic [1:0][dp_pkg::XLEN-1:0]         if_pc,
    input  logic [1:0]                           rt_valid,
    input  logic [1:0][dp_pkg::IDX_W-1:0]        rt_idx,
    input  logic [1:0][dp_pkg::XLEN-1:0]         rt_value,
    input  logic [1:0]                           rob_release,
    input  logic [1:0]                           rs_release,
    input  logic [1:0]                           lsq_release,
    output logic [1:0]                           dp_count,
    output logic [1:0]                           dp_valid,
    output logic [1:0][dp_pkg::XLEN-1:0]         dp_pc,
    output logic [1:0][dp_pkg::IDX_W-1:0]        dp_rs1_idx,
    output logic [1:0][dp_pkg::IDX_W-1:0]        dp_rs2_idx,
    output logic [1:0][dp_pkg::XLEN-1:0]         dp_rs1_value,
    output logic [1:0][dp_pkg::XLEN-1:0]         dp_rs2_value,
    output logic [1:0][dp_pkg::IDX_W-1:0]        dp_dest_idx,
    output logic [1:0]                           dp_has_dest,
    output dp_pkg::alu_func_e [1:0]              dp_alu_func,
    output dp_pkg::fu_sel_e [1:0]                dp_fu_sel,
    output logic [1:0]                           dp_rd_mem,
    output logic [1:0]                           dp_wr_mem,
    output logic [1:0]                           dp_cond_branch,
    output logic [1:0]                           dp_uncond_branch,
    output logic [1:0]                           dp_illegal
);

    // capped free space, one cycle behind dispatch and release.
    logic [1:0] rob_spaces;
    logic [1:0] rs_spaces;
    logic [1:0] lsq_spaces;

    stage_dp stage_dp_i (
        .clock            (clock),
        .if_valid         (if_valid),
        .if_inst          (if_inst),
        .if_pc            (if_pc),
        .rt_valid         (rt_valid),
        .rt_idx           (rt_idx),
        .rt_value         (rt_value),
        .rob_spaces       (rob_spaces),
        .rs_spaces        (rs_spaces),
        .lsq_spaces       (lsq_spaces),
        .dp_count         (dp_count),
        .dp_valid         (dp_valid),
        .dp_pc            (dp_pc),
        .dp_rs1_idx       (dp_rs1_idx),
        .dp_rs2_idx       (dp_rs2_idx),
        .dp_rs1_value     (dp_rs1_value),
        .dp_rs2_value     (dp_rs2_value),
        .dp_dest_idx      (dp_dest_idx),
        .dp_has_dest      (dp_has_dest),
        .dp_alu_func      (dp_alu_func),
        .dp_fu_sel        (dp_fu_sel),
        .dp_rd_mem        (dp_rd_mem),
        .dp_wr_mem        (dp_wr_mem),
        .dp_cond_branch   (dp_cond_branch),
        .dp_uncond_branch (dp_uncond_branch),
        .dp_illegal       (dp_illegal)
    );

    // dispatch count feeds back to consume entries.
    slot_tracker slot_tracker_i (
        .clock       (clock),
        .reset       (reset),
        .dp_count    (dp_count),
        .rob_release (rob_release),
        .rs_release  (rs_release),
        .lsq_release (lsq_release),
        .rob_spaces  (rob_spaces),
        .rs_spaces   (rs_spaces),
        .lsq_spaces  (lsq_spaces)
    );

endmodule

`default_nettype wire

// ==== test/dispatch_tb.sv ====
// Needs the register file zeroed through the retire ports during reset. Fetch slots stay in order.
`default_nettype none

module dispatch_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int SEED             = 58465;
    localparam int RESET_CYCLES     = 16;
    localparam int DECODE_CYCLES    = 40;
    localparam int OPERAND_CYCLES   = 30;
    localparam int COLLISION_ROUNDS = 8;
    localparam int DRAIN_CYCLES     = 5;
    localparam int RELEASE_CYCLES   = 30;
    localparam int REFILL_CYCLES    = 8;
    localparam int ILLEGAL_CYCLES   = 10;
    // setup and settle cycles of every test are covered by the extra 20.
    localparam int TOTAL_CYCLES = RESET_CYCLES + DECODE_CYCLES + OPERAND_CYCLES + 2
        + 2 * COLLISION_ROUNDS + DRAIN_CYCLES + RELEASE_CYCLES + REFILL_CYCLES
        + ILLEGAL_CYCLES + 20;
    localparam int TIMEOUT_NS = TOTAL_CYCLES * 8 + 400;

    logic                    clock;
    logic                    reset;
    logic [1:0]              if_valid;
    logic [1:0][31:0]        if_inst;
    logic [1:0][31:0]        if_pc;
    logic [1:0]              rt_valid;
    logic [1:0][4:0]         rt_idx;
    logic [1:0][31:0]        rt_value;
    logic [1:0]              rob_release;
    logic [1:0]              rs_release;
    logic [1:0]              lsq_release;
    logic [1:0]              dp_count;
    logic [1:0]              dp_valid;
    logic [1:0][31:0]        dp_pc;
    logic [1:0][4:0]         dp_rs1_idx;
    logic [1:0][4:0]         dp_rs2_idx;
    logic [1:0][31:0]        dp_rs1_value;
    logic [1:0][31:0]        dp_rs2_value;
    logic [1:0][4:0]         dp_dest_idx;
    logic [1:0]              dp_has_dest;
    dp_pkg::alu_func_e [1:0] dp_alu_func;
    dp_pkg::fu_sel_e [1:0]   dp_fu_sel;
    logic [1:0]              dp_rd_mem;
    logic [1:0]              dp_wr_mem;
    logic [1:0]              dp_cond_branch;
    logic [1:0]              dp_uncond_branch;
    logic [1:0]              dp_illegal;

    // shadow state of the register file and the free counts.
    logic [31:0] shadow_regs [0:31];
    int          rob_cnt;
    int          rs_cnt;
    int          lsq_cnt;
    int          checks = 0;
    int          errors = 0;
    logic [31:0] next_pc;

    dispatch_top dut_i (.*);

    initial clock = 1'b0;
    always #4 clock = ~clock;

    function automatic int saturate(input int value, input int size);
        return (value < 0) ? 0 : ((value > size) ? size : value);
    endfunction

    function automatic int min_int(input int a, input int b);
        return (a < b) ? a : b;
    endfunction

    // at most two entries are offered per cycle.
    function automatic int cap2(input int value);
        return (value > 2) ? 2 : value;
    endfunction

    function automatic logic [3:0] alu_of_funct3(input logic [2:0] f3, input logic sub);
        case (f3)
            3'b000:  return sub ? 4'(dp_pkg::ALU_SUB) : 4'(dp_pkg::ALU_ADD);
            3'b001:  return 4'(dp_pkg::ALU_SLL);
            3'b010,
            3'b011:  return 4'(dp_pkg::ALU_SLT);
            3'b100:  return 4'(dp_pkg::ALU_XOR);
            3'b101:  return 4'(dp_pkg::ALU_SRL);
            3'b110:  return 4'(dp_pkg::ALU_OR);
            default: return 4'(dp_pkg::ALU_AND);
        endcase
    endfunction

    // flags are {has_dest, rd_mem, wr_mem, cond_branch, uncond_branch, illegal}.
    function automatic void decode_ref(
        input  logic [31:0] inst,
        output logic [3:0]  alu,
        output logic [1:0]  fu,
        output logic [4:0]  rs1,
        output logic [4:0]  rs2,
        output logic [4:0]  rd,
        output logic [5:0]  flags
    );
        logic use1;
        logic use2;
        alu   = 4'(dp_pkg::ALU_ADD);
        fu    = 2'(dp_pkg::FU_ALU);
        use1  = 1'b0;
        use2  = 1'b0;
        flags = 6'b000000;
        case (inst[6:0])
            dp_pkg::OPC_R: begin
                alu   = alu_of_funct3(inst[14:12], inst[30]);
                use1  = 1'b1;
                use2  = 1'b1;
                flags = 6'b100000;
            end
            dp_pkg::OPC_IMM: begin
                alu   = alu_of_funct3(inst[14:12], 1'b0);
                use1  = 1'b1;
                flags = 6'b100000;
            end
            dp_pkg::OPC_LOAD: begin
                fu    = 2'(dp_pkg::FU_MEM);
                use1  = 1'b1;
                flags = 6'b110000;
            end
            dp_pkg::OPC_STORE: begin
                fu    = 2'(dp_pkg::FU_MEM);
                use1  = 1'b1;
                use2  = 1'b1;
                flags = 6'b001000;
            end
            dp_pkg::OPC_BRANCH: begin
                alu   = 4'(dp_pkg::ALU_SUB);
                fu    = 2'(dp_pkg::FU_BR);
                use1  = 1'b1;
                use2  = 1'b1;
                flags = 6'b000100;
            end
            dp_pkg::OPC_JAL: begin
                fu    = 2'(dp_pkg::FU_BR);
                flags = 6'b100010;
            end
            dp_pkg::OPC_LUI: begin
                flags = 6'b100000;
            end
            default: begin
                flags = 6'b000001;
            end
        endcase
        rs1 = use1 ? inst[19:15] : 5'd0;
        rs2 = use2 ? inst[24:20] : 5'd0;
        rd  = flags[5] ? inst[11:7] : 5'd0;
    endfunction

    function automatic bit is_legal(input logic [6:0] opc);
        return opc inside {dp_pkg::OPC_R, dp_pkg::OPC_IMM, dp_pkg::OPC_LOAD, dp_pkg::OPC_STORE,
                           dp_pkg::OPC_BRANCH, dp_pkg::OPC_JAL, dp_pkg::OPC_LUI};
    endfunction

    function automatic logic [31:0] random_legal_inst();
        logic [31:0] r;
        logic [6:0]  opc;
        case ($urandom() % 7)
            0:       opc = dp_pkg::OPC_R;
            1:       opc = dp_pkg::OPC_IMM;
            2:       opc = dp_pkg::OPC_LOAD;
            3:       opc = dp_pkg::OPC_STORE;
            4:       opc = dp_pkg::OPC_BRANCH;
            5:       opc = dp_pkg::OPC_JAL;
            default: opc = dp_pkg::OPC_LUI;
        endcase
        r = $urandom();
        return {r[31:7], opc};
    endfunction

    function automatic logic [31:0] unknown_opcode_inst();
        logic [31:0] r;
        r = $urandom();
        while (is_legal(r[6:0])) begin
            r = $urandom();
        end
        return r;
    endfunction

    function automatic logic [31:0] reg_reg_inst(input logic [4:0] rs1, input logic [4:0] rs2);
        logic [31:0] r;
        r = $urandom();
        return {r[31:25], rs2, rs1, r[14:7], 7'(dp_pkg::OPC_R)};
    endfunction

    task automatic compare_field(
        input string       name,
        input int          slot,
        input logic [31:0] expected,
        input logic [31:0] actual
    );
        checks++;
        assert (actual === expected) else begin
            $display("ERR %s[%0d] expected %h actual %h", name, slot, expected, actual);
            errors++;
        end
    endtask

    task automatic present(input logic [1:0] valid, input logic [31:0] inst0,
                           input logic [31:0] inst1);
        if_valid   = valid;
        if_inst[0] = inst0;
        if_inst[1] = inst1;
        if_pc[0]   = next_pc;
        if_pc[1]   = next_pc + 32'd4;
        next_pc    = next_pc + 32'd8;
    endtask

    task automatic set_release(input logic [1:0] rob, input logic [1:0] rs, input logic [1:0] lsq);
        rob_release = rob;
        rs_release  = rs;
        lsq_release = lsq;
    endtask

    task automatic finish_test(input string name, input int start_errors);
        @(posedge clock);
        $display("%s: %0d errors", name, errors - start_errors);
    endtask

    task automatic decode_sweep();
        logic [1:0] valid;
        for (int c = 0; c < DECODE_CYCLES; c++) begin
            @(negedge clock);
            set_release(2'd2, 2'd2, 2'd2);
            case ($urandom() % 3)
                0:       valid = 2'b00;
                1:       valid = 2'b01;
                default: valid = 2'b11;
            endcase
            present(valid, random_legal_inst(), random_legal_inst());
        end
    endtask

    task automatic operand_reads();
        // writes to x0 must never show up.
        @(negedge clock);
        set_release(2'd2, 2'd2, 2'd2);
        rt_valid    = 2'b11;
        rt_idx      = '0;
        rt_value[0] = 32'hdead_beef;
        rt_value[1] = 32'h1234_5678;
        present(2'b11, reg_reg_inst(5'd0, 5'd0), reg_reg_inst(5'd0, 5'd0));
        @(negedge clock);
        rt_valid = 2'b00;
        present(2'b11, reg_reg_inst(5'd0, 5'd0), reg_reg_inst(5'd0, 5'd0));
        for (int c = 0; c < OPERAND_CYCLES; c++) begin
            @(negedge clock);
            rt_valid    = 2'($urandom());
            rt_idx[0]   = 5'($urandom());
            rt_idx[1]   = 5'($urandom());
            rt_value[0] = $urandom();
            rt_value[1] = $urandom();
            present(2'b11, reg_reg_inst(5'($urandom()), 5'($urandom())),
                    reg_reg_inst(5'($urandom()), 5'($urandom())));
        end
    endtask

    task automatic retire_collision();
        logic [4:0] idx;
        for (int r = 0; r < COLLISION_ROUNDS; r++) begin
            @(negedge clock);
            set_release(2'd2, 2'd2, 2'd2);
            idx         = 5'(1 + $urandom() % 31);
            rt_valid    = 2'b11;
            rt_idx[0]   = idx;
            rt_idx[1]   = idx;
            rt_value[0] = $urandom();
            rt_value[1] = $urandom();
            present(2'b00, '0, '0);
            @(negedge clock);
            rt_valid = 2'b00;
            present(2'b11, reg_reg_inst(idx, idx), reg_reg_inst(idx, 5'd0));
        end
    endtask

    task automatic drain_queues();
        // a single dispatch first, so RS and LSQ pass through one free entry.
        for (int c = 0; c < DRAIN_CYCLES; c++) begin
            @(negedge clock);
            set_release(2'd0, 2'd0, 2'd0);
            rt_valid = 2'b00;
            present((c == 0) ? 2'b01 : 2'b11, random_legal_inst(), random_legal_inst());
        end
    endtask

    task automatic refill_queues();
        for (int c = 0; c < RELEASE_CYCLES; c++) begin
            @(negedge clock);
            set_release(2'($urandom() % 3), 2'($urandom() % 3), 2'($urandom() % 3));
            present(2'b11, random_legal_inst(), random_legal_inst());
        end
        // saturate every count, then dispatch two per cycle again.
        for (int c = 0; c < REFILL_CYCLES; c++) begin
            @(negedge clock);
            if (c < REFILL_CYCLES - 2) begin
                set_release(2'd2, 2'd2, 2'd2);
                present(2'b00, '0, '0);
            end else begin
                set_release(2'd0, 2'd0, 2'd0);
                present(2'b11, random_legal_inst(), random_legal_inst());
            end
        end
    endtask

    task automatic illegal_opcodes();
        for (int c = 0; c < ILLEGAL_CYCLES; c++) begin
            @(negedge clock);
            set_release(2'd2, 2'd2, 2'd2);
            rt_valid    = 2'b11;
            rt_idx[0]   = 5'(1 + c);
            rt_idx[1]   = 5'(2 + c);
            rt_value[0] = $urandom();
            rt_value[1] = $urandom();
            present(2'b11, unknown_opcode_inst(), unknown_opcode_inst());
        end
    endtask

    // sampled well after the falling edge, applied as of the next rising edge.
    always begin : compare_outputs
        int         exp_count;
        logic [3:0] alu;
        logic [1:0] fu;
        logic [4:0] rs1;
        logic [4:0] rs2;
        logic [4:0] rd;
        logic [5:0] flags;
        @(negedge clock);
        #3;
        if (reset) begin
            rob_cnt = dp_pkg::ROB_SIZE;
            rs_cnt  = dp_pkg::RS_SIZE;
            lsq_cnt = dp_pkg::LSQ_SIZE;
        end else begin
            exp_count = if_valid[0] ? (if_valid[1] ? 2 : 1) : 0;
            exp_count = min_int(exp_count, cap2(rob_cnt));
            exp_count = min_int(min_int(exp_count, cap2(rs_cnt)), cap2(lsq_cnt));
            compare_field("dp_count", 0, exp_count, dp_count);
            for (int s = 0; s < 2; s++) begin
                compare_field("dp_valid", s, (s < exp_count), dp_valid[s]);
                if (s < exp_count) begin
                    decode_ref(if_inst[s], alu, fu, rs1, rs2, rd, flags);
                    compare_field("dp_pc", s, if_pc[s], dp_pc[s]);
                    compare_field("dp_alu_func", s, alu, dp_alu_func[s]);
                    compare_field("dp_fu_sel", s, fu, dp_fu_sel[s]);
                    compare_field("dp_rs1_idx", s, rs1, dp_rs1_idx[s]);
                    compare_field("dp_rs2_idx", s, rs2, dp_rs2_idx[s]);
                    compare_field("dp_dest_idx", s, rd, dp_dest_idx[s]);
                    compare_field("dp_has_dest", s, flags[5], dp_has_dest[s]);
                    compare_field("dp_rd_mem", s, flags[4], dp_rd_mem[s]);
                    compare_field("dp_wr_mem", s, flags[3], dp_wr_mem[s]);
                    compare_field("dp_cond_branch", s, flags[2], dp_cond_branch[s]);
                    compare_field("dp_uncond_branch", s, flags[1], dp_uncond_branch[s]);
                    compare_field("dp_illegal", s, flags[0], dp_illegal[s]);
                    compare_field("dp_rs1_value", s, shadow_regs[rs1], dp_rs1_value[s]);
                    compare_field("dp_rs2_value", s, shadow_regs[rs2], dp_rs2_value[s]);
                end
            end
            rob_cnt = saturate(rob_cnt + int'(rob_release) - exp_count, dp_pkg::ROB_SIZE);
            rs_cnt  = saturate(rs_cnt + int'(rs_release) - exp_count, dp_pkg::RS_SIZE);
            lsq_cnt = saturate(lsq_cnt + int'(lsq_release) - exp_count, dp_pkg::LSQ_SIZE);
        end
        // port 1 goes last and wins a shared index.
        for (int p = 0; p < 2; p++) begin
            if (rt_valid[p] && (rt_idx[p] != 5'd0)) begin
                shadow_regs[rt_idx[p]] = rt_value[p];
            end
        end
    end

    initial begin : stimulus
        int start;
        void'($urandom(SEED));
        for (int r = 0; r < 32; r++) begin
            shadow_regs[r] = '0;
        end
        next_pc  = 32'h0000_1000;
        reset    = 1'b1;
        if_valid = 2'b00;
        if_inst  = '0;
        if_pc    = '0;
        rt_valid = 2'b11;
        rt_value = '0;
        rt_idx[0] = 5'd0;
        rt_idx[1] = 5'd1;
        set_release(2'd0, 2'd0, 2'd0);
        // two registers cleared per reset cycle.
        for (int c = 1; c < RESET_CYCLES; c++) begin
            @(negedge clock);
            rt_idx[0] = 5'(2 * c);
            rt_idx[1] = 5'(2 * c + 1);
        end
        @(negedge clock);
        reset    = 1'b0;
        rt_valid = 2'b00;

        start = errors;
        decode_sweep();
        finish_test("decode", start);
        start = errors;
        operand_reads();
        finish_test("operand read", start);
        start = errors;
        retire_collision();
        finish_test("write collision", start);
        start = errors;
        drain_queues();
        finish_test("back-pressure", start);
        start = errors;
        refill_queues();
        finish_test("release", start);
        start = errors;
        illegal_opcodes();
        finish_test("illegal opcode", start);

        @(negedge clock);
        rt_valid = 2'b00;
        present(2'b00, '0, '0);
        @(posedge clock);
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    initial begin : watchdog
        #(TIMEOUT_NS);
        $display("timeout: the tests did not finish within %0d ns", TIMEOUT_NS);
        $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
rtl/dp_pkg.sv
rtl/decoder.sv
rtl/regfile.sv
rtl/slot_tracker.sv
rtl/stage_dp.sv
rtl/dispatch_top.sv
test/dispatch_tb.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module dispatch_tb -o dispatch_sim
	./obj_dir/dispatch_sim > sim.log 2>&1; cat sim.log
	grep -q "No errors" sim.log

clean:
	rm -rf obj_dir sim.log
